// ==== ub_cfg_pkg.sv ====
package ub_cfg_pkg;

    // memory sizing
    // number of 16-bit words held in the scratchpad
    localparam int UB_DEPTH = 50;

    // width of an address, a pointer or a burst count
    localparam int UB_ADDR_W = 6;

    // width of one data word
    localparam int UB_DATA_W = 16;

    // read channel layout
    // input, weight and bias each get their own channel
    localparam int UB_NUM_RD = 3;

    // left side of the systolic array
    localparam int RD_CH_INPUT = 0;

    // top side of the systolic array
    localparam int RD_CH_WEIGHT = 1;

    // bias module in the vector unit
    localparam int RD_CH_BIAS = 2;

endpackage

// ==== ub_types_pkg.sv ====
package ub_types_pkg;

    // meaningful widths
    typedef logic [ub_cfg_pkg::UB_ADDR_W-1:0] ub_addr_t;
    typedef logic [ub_cfg_pkg::UB_ADDR_W-1:0] ub_count_t;
    typedef logic [ub_cfg_pkg::UB_DATA_W-1:0] ub_word_t;

    // read channel FSM
    typedef enum logic [1:0] {
        READ_IDLE   = 2'b00,
        READ_ACTIVE = 2'b10
    } rd_state_e;

    // write request from the vector unit
    // addr_load reloads the write pointer
    // the lanes carry up to two words
    typedef struct packed {
        logic     addr_load;
        ub_addr_t addr;
        ub_word_t data_1;
        logic     valid_1;
        ub_word_t data_2;
        logic     valid_2;
    } ub_wr_req_t;

    // read request with a one-cycle start strobe
    typedef struct packed {
        logic      start;
        logic      transpose;
        ub_addr_t  addr;
        ub_count_t count;
    } ub_rd_req_t;

    // one output beat of a staggered burst
    // an invalid lane always carries zero data
    typedef struct packed {
        ub_word_t data_1;
        logic     valid_1;
        ub_word_t data_2;
        logic     valid_2;
    } ub_lane_pair_t;

endpackage

// ==== ub_storage.sv ====
`timescale 1ns/1ps

module ub_storage (
    input  logic                                                clk,
    input  logic                                                rst,
    input  ub_types_pkg::ub_wr_req_t                            wr,
    input  ub_types_pkg::ub_addr_t [ub_cfg_pkg::UB_NUM_RD-1:0]  rd_addr_a,
    input  ub_types_pkg::ub_addr_t [ub_cfg_pkg::UB_NUM_RD-1:0]  rd_addr_b,
    output ub_types_pkg::ub_word_t [ub_cfg_pkg::UB_NUM_RD-1:0]  rd_data_a,
    output ub_types_pkg::ub_word_t [ub_cfg_pkg::UB_NUM_RD-1:0]  rd_data_b
);

    ub_types_pkg::ub_word_t mem [ub_cfg_pkg::UB_DEPTH];

    ub_types_pkg::ub_addr_t wr_ptr;

    // index of the upper word is one bit wider so it cannot wrap into range
    logic [ub_cfg_pkg::UB_ADDR_W:0] wr_idx_hi;
    logic                           wr_lo_ok;
    logic                           wr_hi_ok;
    logic [1:0]                     wr_step;

    assign wr_idx_hi = {1'b0, wr_ptr} + 1'b1;
    assign wr_lo_ok  = (wr_ptr < ub_cfg_pkg::UB_DEPTH);
    assign wr_hi_ok  = (wr_idx_hi < ub_cfg_pkg::UB_DEPTH);

    // number of words stored this cycle
    assign wr_step = {1'b0, wr.valid_1} + {1'b0, wr.valid_2};

    // write pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr.addr_load) begin
            // load wins over the advance
            wr_ptr <= wr.addr;
        end else begin
            wr_ptr <= wr_ptr + ub_types_pkg::ub_addr_t'(wr_step);
        end
    end

    // word memory
    // same-cycle writes always land at the old pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ub_cfg_pkg::UB_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wr.valid_1 && wr.valid_2) begin
                // lane 1 goes above lane 2
                if (wr_hi_ok) begin
                    mem[wr_idx_hi[ub_cfg_pkg::UB_ADDR_W-1:0]] <= wr.data_1;
                end
                if (wr_lo_ok) begin
                    mem[wr_ptr] <= wr.data_2;
                end
            end else if (wr.valid_1) begin
                if (wr_lo_ok) begin
                    mem[wr_ptr] <= wr.data_1;
                end
            end else if (wr.valid_2) begin
                if (wr_lo_ok) begin
                    mem[wr_ptr] <= wr.data_2;
                end
            end
        end
    end

    // two combinational taps per read channel
    // taps past the end of memory read zero
    always_comb begin
        for (int ch = 0; ch < ub_cfg_pkg::UB_NUM_RD; ch++) begin
            if (rd_addr_a[ch] < ub_cfg_pkg::UB_DEPTH) begin
                rd_data_a[ch] = mem[rd_addr_a[ch]];
            end else begin
                rd_data_a[ch] = '0;
            end

            if (rd_addr_b[ch] < ub_cfg_pkg::UB_DEPTH) begin
                rd_data_b[ch] = mem[rd_addr_b[ch]];
            end else begin
                rd_data_b[ch] = '0;
            end
        end
    end

endmodule

// ==== ub_read_channel.sv ====
`timescale 1ns/1ps

module ub_read_channel (
    input  logic                        clk,
    input  logic                        rst,
    input  ub_types_pkg::ub_rd_req_t    req,
    output ub_types_pkg::ub_addr_t      addr_a,
    output ub_types_pkg::ub_addr_t      addr_b,
    input  ub_types_pkg::ub_word_t      data_a,
    input  ub_types_pkg::ub_word_t      data_b,
    output ub_types_pkg::ub_lane_pair_t lanes
);

    ub_types_pkg::rd_state_e     state;
    ub_types_pkg::rd_state_e     state_next;

    ub_types_pkg::ub_addr_t      rd_ptr;
    ub_types_pkg::ub_count_t     remaining;
    logic                        transpose_q;

    ub_types_pkg::ub_lane_pair_t lanes_next;

    // start address straight from the request when idle
    assign addr_a = (state == ub_types_pkg::READ_IDLE) ? req.addr : rd_ptr;
    assign addr_b = rd_ptr + ub_types_pkg::ub_addr_t'(1);

    // next state
    always_comb begin
        case (state)
            ub_types_pkg::READ_IDLE: begin
                // a single-word burst is done after its first beat
                if (req.start && (req.count > ub_types_pkg::ub_count_t'(1))) begin
                    state_next = ub_types_pkg::READ_ACTIVE;
                end else begin
                    state_next = ub_types_pkg::READ_IDLE;
                end
            end

            ub_types_pkg::READ_ACTIVE: begin
                // remaining of 2 drains to 0 first, which costs one empty cycle
                if (remaining <= ub_types_pkg::ub_count_t'(1)) begin
                    state_next = ub_types_pkg::READ_IDLE;
                end else begin
                    state_next = ub_types_pkg::READ_ACTIVE;
                end
            end

            default: begin
                state_next = ub_types_pkg::READ_IDLE;
            end
        endcase
    end

    // beat formation
    always_comb begin
        lanes_next = '0;

        case (state)
            ub_types_pkg::READ_IDLE: begin
                // first word alone on lane 1
                if (req.start) begin
                    lanes_next.data_1  = data_a;
                    lanes_next.valid_1 = 1'b1;
                end
            end

            ub_types_pkg::READ_ACTIVE: begin
                if (remaining > ub_types_pkg::ub_count_t'(1)) begin
                    lanes_next.valid_1 = 1'b1;
                    lanes_next.valid_2 = 1'b1;
                    if (transpose_q) begin
                        lanes_next.data_1 = data_a;
                        lanes_next.data_2 = data_b;
                    end else begin
                        lanes_next.data_1 = data_b;
                        lanes_next.data_2 = data_a;
                    end
                end else if (remaining == ub_types_pkg::ub_count_t'(1)) begin
                    // leftover word alone on lane 2
                    lanes_next.data_2  = data_a;
                    lanes_next.valid_2 = 1'b1;
                end
            end

            default: begin
                lanes_next = '0;
            end
        endcase
    end

    // pointer, count and latched transpose
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ub_types_pkg::READ_IDLE;
            rd_ptr      <= '0;
            remaining   <= '0;
            transpose_q <= 1'b0;
        end else begin
            state <= state_next;

            if (state == ub_types_pkg::READ_IDLE) begin
                if (req.start) begin
                    rd_ptr      <= req.addr + ub_types_pkg::ub_addr_t'(1);
                    remaining   <= req.count - ub_types_pkg::ub_count_t'(1);
                    transpose_q <= req.transpose;
                end
            end else if (remaining > ub_types_pkg::ub_count_t'(1)) begin
                rd_ptr    <= rd_ptr + ub_types_pkg::ub_addr_t'(2);
                remaining <= remaining - ub_types_pkg::ub_count_t'(2);
            end else begin
                remaining <= '0;
            end
        end
    end

    // registered output beat
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lanes <= '0;
        end else begin
            lanes <= lanes_next;
        end
    end

endmodule

// ==== unified_buffer.sv ====
`timescale 1ns/1ps

module unified_buffer (
    input  logic                                                     clk,
    input  logic                                                     rst,
    input  ub_types_pkg::ub_wr_req_t                                 wr,
    input  ub_types_pkg::ub_rd_req_t    [ub_cfg_pkg::UB_NUM_RD-1:0]  rd_req,
    output ub_types_pkg::ub_lane_pair_t [ub_cfg_pkg::UB_NUM_RD-1:0]  rd_out
);

    // tap addresses from the channels, tap data back from storage
    ub_types_pkg::ub_addr_t [ub_cfg_pkg::UB_NUM_RD-1:0] tap_addr_a;
    ub_types_pkg::ub_addr_t [ub_cfg_pkg::UB_NUM_RD-1:0] tap_addr_b;
    ub_types_pkg::ub_word_t [ub_cfg_pkg::UB_NUM_RD-1:0] tap_data_a;
    ub_types_pkg::ub_word_t [ub_cfg_pkg::UB_NUM_RD-1:0] tap_data_b;

    ub_storage u_storage (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .rd_addr_a (tap_addr_a),
        .rd_addr_b (tap_addr_b),
        .rd_data_a (tap_data_a),
        .rd_data_b (tap_data_b)
    );

    // one channel each for input, weight and bias
    for (genvar ch = 0; ch < ub_cfg_pkg::UB_NUM_RD; ch++) begin : g_rd_ch
        ub_read_channel u_rd_channel (
            .clk    (clk),
            .rst    (rst),
            .req    (rd_req[ch]),
            .addr_a (tap_addr_a[ch]),
            .addr_b (tap_addr_b[ch]),
            .data_a (tap_data_a[ch]),
            .data_b (tap_data_b[ch]),
            .lanes  (rd_out[ch])
        );
    end

endmodule

// ==== tb_ub_cases.svh ====
`ifndef TB_UB_CASES_SVH
`define TB_UB_CASES_SVH

// operation kinds
localparam logic [1:0] OP_WRITE = 2'd0;
localparam logic [1:0] OP_LOAD  = 2'd1;
localparam logic [1:0] OP_READ  = 2'd2;

localparam logic [1:0] CH_IN = 2'(ub_cfg_pkg::RD_CH_INPUT);
localparam logic [1:0] CH_WT = 2'(ub_cfg_pkg::RD_CH_WEIGHT);
localparam logic [1:0] CH_BS = 2'(ub_cfg_pkg::RD_CH_BIAS);

// for write rows count is the number of write cycles and lanes is {valid_1, valid_2}
// gap is the number of cycles run after the row
// settle waits for all traffic to finish
typedef struct packed {
    logic [1:0]              op;
    logic [1:0]              ch;
    ub_types_pkg::ub_addr_t  addr;
    ub_types_pkg::ub_count_t count;
    logic                    transpose;
    logic [1:0]              lanes;
    logic [3:0]              gap;
    logic                    settle;
} case_row_t;

localparam int NUM_CASES = 26;

// op, ch, addr, count, transpose, lanes, gap, settle
localparam case_row_t CASES [NUM_CASES] = '{
    '{OP_READ,  CH_WT, 6'd0,  6'd4, 1'b0, 2'b00, 4'd0, 1'b1},
    '{OP_LOAD,  CH_IN, 6'd10, 6'd0, 1'b0, 2'b00, 4'd1, 1'b0},
    '{OP_WRITE, CH_IN, 6'd0,  6'd2, 1'b0, 2'b11, 4'd2, 1'b0},
    '{OP_WRITE, CH_IN, 6'd0,  6'd2, 1'b0, 2'b10, 4'd2, 1'b0},
    '{OP_WRITE, CH_IN, 6'd0,  6'd2, 1'b0, 2'b01, 4'd2, 1'b1},
    '{OP_READ,  CH_WT, 6'd10, 6'd8, 1'b0, 2'b00, 4'd0, 1'b1},
    // load with a pair write in the same cycle puts the pair at 18 and 19
    '{OP_LOAD,  CH_IN, 6'd30, 6'd0, 1'b0, 2'b00, 4'd0, 1'b0},
    '{OP_WRITE, CH_IN, 6'd0,  6'd1, 1'b0, 2'b11, 4'd1, 1'b0},
    '{OP_WRITE, CH_IN, 6'd0,  6'd3, 1'b0, 2'b11, 4'd3, 1'b1},
    '{OP_READ,  CH_WT, 6'd16, 6'd4, 1'b0, 2'b00, 4'd0, 1'b1},
    // bias burst lengths with back-to-back starts and starts into a busy channel
    '{OP_READ,  CH_BS, 6'd30, 6'd1, 1'b0, 2'b00, 4'd1, 1'b0},
    '{OP_READ,  CH_BS, 6'd30, 6'd2, 1'b0, 2'b00, 4'd0, 1'b1},
    '{OP_READ,  CH_BS, 6'd30, 6'd5, 1'b0, 2'b00, 4'd3, 1'b0},
    '{OP_READ,  CH_BS, 6'd0,  6'd3, 1'b0, 2'b00, 4'd1, 1'b0},
    '{OP_READ,  CH_BS, 6'd10, 6'd6, 1'b0, 2'b00, 4'd2, 1'b0},
    '{OP_READ,  CH_BS, 6'd0,  6'd3, 1'b0, 2'b00, 4'd0, 1'b1},
    // transposed input reads
    '{OP_READ,  CH_IN, 6'd10, 6'd7, 1'b1, 2'b00, 4'd0, 1'b1},
    '{OP_READ,  CH_IN, 6'd30, 6'd6, 1'b1, 2'b00, 4'd0, 1'b1},
    // words past the top of memory are dropped
    '{OP_LOAD,  CH_IN, 6'd48, 6'd0, 1'b0, 2'b00, 4'd1, 1'b0},
    '{OP_WRITE, CH_IN, 6'd0,  6'd2, 1'b0, 2'b11, 4'd2, 1'b1},
    '{OP_READ,  CH_WT, 6'd47, 6'd5, 1'b0, 2'b00, 4'd0, 1'b1},
    // three channels at once while lane 2 writes run from 40
    '{OP_LOAD,  CH_IN, 6'd40, 6'd0, 1'b0, 2'b00, 4'd1, 1'b0},
    '{OP_WRITE, CH_IN, 6'd0,  6'd4, 1'b0, 2'b01, 4'd1, 1'b0},
    '{OP_READ,  CH_IN, 6'd41, 6'd5, 1'b0, 2'b00, 4'd0, 1'b0},
    '{OP_READ,  CH_WT, 6'd12, 6'd4, 1'b0, 2'b00, 4'd0, 1'b0},
    '{OP_READ,  CH_BS, 6'd30, 6'd3, 1'b0, 2'b00, 4'd0, 1'b1}
};

`endif

// ==== tb_unified_buffer.sv ====
`timescale 1ns/1ps

module tb_unified_buffer;

    localparam int NUM_RD = ub_cfg_pkg::UB_NUM_RD;
    localparam int DEPTH  = ub_cfg_pkg::UB_DEPTH;

    logic                                       clk;
    logic                                       rst;
    ub_types_pkg::ub_wr_req_t                   wr;
    ub_types_pkg::ub_rd_req_t    [NUM_RD-1:0]   rd_req;
    ub_types_pkg::ub_lane_pair_t [NUM_RD-1:0]   rd_out;

`include "tb_ub_cases.svh"

    // shadow of the scratchpad and its write pointer
    ub_types_pkg::ub_word_t  shadow [DEPTH];
    ub_types_pkg::ub_addr_t  shadow_ptr;

    // expected burst per channel
    ub_types_pkg::ub_addr_t  burst_base  [NUM_RD];
    ub_types_pkg::ub_count_t burst_len   [NUM_RD];
    logic                    burst_tr    [NUM_RD];
    int                      burst_beat  [NUM_RD];
    int                      burst_beats [NUM_RD];

    // stimulus for the next cycle and the running write burst
    ub_types_pkg::ub_wr_req_t              next_wr;
    ub_types_pkg::ub_rd_req_t [NUM_RD-1:0] next_rd;
    int                                    wr_left;
    logic [1:0]                            wr_lanes;

    int checks;
    int mismatches;
    int cycle_cnt;

    unified_buffer dut_i (
        .clk    (clk),
        .rst    (rst),
        .wr     (wr),
        .rd_req (rd_req),
        .rd_out (rd_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int beats_for(ub_types_pkg::ub_count_t len);
        int rest;
        rest = int'(len) - 1;
        // a lone last word or a trailing empty cycle both cost one more
        if (rest >= 1) begin
            return 2 + rest / 2;
        end else begin
            return 1;
        end
    endfunction

    function automatic ub_types_pkg::ub_word_t mem_word(ub_types_pkg::ub_addr_t addr);
        if (int'(addr) < DEPTH) begin
            return shadow[addr];
        end else begin
            return '0;
        end
    endfunction

    function automatic ub_types_pkg::ub_lane_pair_t expected_beat(int ch);
        ub_types_pkg::ub_lane_pair_t beat;
        ub_types_pkg::ub_addr_t      p;
        ub_types_pkg::ub_word_t      lo;
        ub_types_pkg::ub_word_t      hi;
        int                          k;
        int                          rest;
        beat = '0;
        k    = burst_beat[ch];
        rest = int'(burst_len[ch]) - 1;
        if (k < burst_beats[ch]) begin
            if (k == 0) begin
                beat.data_1  = mem_word(burst_base[ch]);
                beat.valid_1 = 1'b1;
            end else if (k <= rest / 2) begin
                p  = burst_base[ch] + ub_types_pkg::ub_addr_t'(2 * k - 1);
                lo = mem_word(p);
                hi = mem_word(p + ub_types_pkg::ub_addr_t'(1));
                beat.data_1  = burst_tr[ch] ? lo : hi;
                beat.data_2  = burst_tr[ch] ? hi : lo;
                beat.valid_1 = 1'b1;
                beat.valid_2 = 1'b1;
            end else if (rest % 2 == 1) begin
                p = burst_base[ch] + ub_types_pkg::ub_addr_t'(rest);
                beat.data_2  = mem_word(p);
                beat.valid_2 = 1'b1;
            end
        end
        return beat;
    endfunction

    function automatic int table_cycles();
        int sum;
        sum = 0;
        for (int r = 0; r < NUM_CASES; r++) begin
            sum += int'(CASES[r].gap) + int'(CASES[r].count) + 6;
        end
        return sum;
    endfunction

    task automatic check_word(string name, ub_types_pkg::ub_word_t got,
                              ub_types_pkg::ub_word_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_valid(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_beat(int ch, ub_types_pkg::ub_lane_pair_t exp);
        check_word($sformatf("rd_out[%0d].data_1", ch), rd_out[ch].data_1, exp.data_1);
        check_valid($sformatf("rd_out[%0d].valid_1", ch), rd_out[ch].valid_1, exp.valid_1);
        check_word($sformatf("rd_out[%0d].data_2", ch), rd_out[ch].data_2, exp.data_2);
        check_valid($sformatf("rd_out[%0d].valid_2", ch), rd_out[ch].valid_2, exp.valid_2);
    endtask

    task automatic apply_write(ub_types_pkg::ub_wr_req_t w);
        int lo_idx;
        int step;
        lo_idx = int'(shadow_ptr);
        step   = int'(w.valid_1) + int'(w.valid_2);
        if (w.valid_1 && w.valid_2) begin
            if (lo_idx + 1 < DEPTH) shadow[lo_idx + 1] = w.data_1;
            if (lo_idx < DEPTH) shadow[lo_idx] = w.data_2;
        end else if (step == 1 && lo_idx < DEPTH) begin
            shadow[lo_idx] = w.valid_1 ? w.data_1 : w.data_2;
        end
        if (w.addr_load) begin
            shadow_ptr = w.addr;
        end else begin
            shadow_ptr = shadow_ptr + ub_types_pkg::ub_addr_t'(step);
        end
    endtask

    // drive one cycle and check the beats produced at its edge
    task automatic run_cycle();
        if (wr_left > 0) begin
            next_wr.valid_1 = wr_lanes[1];
            next_wr.valid_2 = wr_lanes[0];
            next_wr.data_1  = wr_lanes[1] ? ub_types_pkg::ub_word_t'($urandom) : '0;
            next_wr.data_2  = wr_lanes[0] ? ub_types_pkg::ub_word_t'($urandom) : '0;
            wr_left--;
        end
        wr      = next_wr;
        rd_req  = next_rd;
        next_wr = '0;
        next_rd = '0;
        @(posedge clk);
        #1;
        for (int ch = 0; ch < NUM_RD; ch++) begin
            // busy channels drop new starts
            if (rd_req[ch].start && burst_beat[ch] >= burst_beats[ch]) begin
                burst_base[ch]  = rd_req[ch].addr;
                burst_len[ch]   = rd_req[ch].count;
                burst_tr[ch]    = rd_req[ch].transpose;
                burst_beat[ch]  = 0;
                burst_beats[ch] = beats_for(rd_req[ch].count);
            end
            compare_beat(ch, expected_beat(ch));
            if (burst_beat[ch] < burst_beats[ch]) burst_beat[ch]++;
        end
        // memory reads above saw the old words
        apply_write(wr);
    endtask

    function automatic logic any_busy();
        logic busy;
        busy = (wr_left > 0);
        for (int ch = 0; ch < NUM_RD; ch++) begin
            if (burst_beat[ch] < burst_beats[ch]) busy = 1'b1;
        end
        return busy;
    endfunction

    task automatic drain_all();
        run_cycle();
        while (any_busy()) run_cycle();
        run_cycle();
        run_cycle();
    endtask

    task automatic apply_row(case_row_t row);
        case (row.op)
            OP_WRITE: begin
                wr_left  = int'(row.count);
                wr_lanes = row.lanes;
            end
            OP_LOAD: begin
                next_wr.addr_load = 1'b1;
                next_wr.addr      = row.addr;
            end
            OP_READ: begin
                next_rd[row.ch].start     = 1'b1;
                next_rd[row.ch].transpose = row.transpose;
                next_rd[row.ch].addr      = row.addr;
                next_rd[row.ch].count     = row.count;
            end
            default: begin
            end
        endcase
    endtask

    initial begin : stimulus
        void'($urandom(32'h348a));
        rst        = 1'b1;
        wr         = '0;
        rd_req     = '0;
        next_wr    = '0;
        next_rd    = '0;
        wr_left    = 0;
        wr_lanes   = 2'b00;
        shadow_ptr = '0;
        checks     = 0;
        mismatches = 0;
        for (int i = 0; i < DEPTH; i++) shadow[i] = '0;
        for (int ch = 0; ch < NUM_RD; ch++) begin
            burst_base[ch]  = '0;
            burst_len[ch]   = '0;
            burst_tr[ch]    = 1'b0;
            burst_beat[ch]  = 0;
            burst_beats[ch] = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        // all beats empty out of reset
        for (int ch = 0; ch < NUM_RD; ch++) begin
            compare_beat(ch, '0);
        end
        rst = 1'b0;
        for (int r = 0; r < NUM_CASES; r++) begin
            apply_row(CASES[r]);
            repeat (int'(CASES[r].gap)) run_cycle();
            if (CASES[r].settle) drain_all();
        end
        drain_all();
        $display("checks: %0d, mismatches: %0d", checks, mismatches);
        if (mismatches == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit     = 2 * table_cycles() + 50;
        cycle_cnt = 0;
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("checks: %0d, mismatches: %0d", checks, mismatches);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
ub_cfg_pkg.sv
ub_types_pkg.sv
ub_storage.sv
ub_read_channel.sv
unified_buffer.sv
tb_unified_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the unified buffer testbench with Verilator

LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f \
    --top-module tb_unified_buffer -o tb_unified_buffer \
    && ./obj_dir/tb_unified_buffer > "$LOG" 2>&1 \
    || { echo "build or simulation failed"; exit 1; }

cat "$LOG"

grep -q "^Finished with no errors$" "$LOG" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
